// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_snac
FILELIST  := all.f
PASS_MSG  := Done: no errors

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
snac_pkg.sv
snac_mode_ctrl.sv
snac_serlatch_reader.sv
snac_pce_reader.sv
snac_port_combiner.sv
snac_top.sv
tb_pad_model.sv
tb_snac.sv

// File: snac_mode_ctrl.sv
// Controller type decoder and fractional strobe generator that paces both readers
`timescale 1ns/100ps
`default_nettype none

module snac_mode_ctrl import snac_pkg::*; #(
    parameter int unsigned MASTER_CLK_FREQ = 50_000_000
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire snac_type_e i_cont_type,
    output reader_sel_t     o_sel,
    output serlatch_var_e   o_sl_var,
    output logic            o_stb,
    output logic            o_restart
);

    // Step is (2 * rate / clock) scaled by 2^32
    function automatic logic [31:0] step_of(input logic [31:0] hz);
        logic [63:0] num;
        num = (64'(hz) * 64'd2) << 32;
        return 32'(num / 64'(MASTER_CLK_FREQ));
    endfunction

    localparam logic [31:0] STEP_SL_NORMAL = step_of(SERLATCH_NORMAL_HZ);
    localparam logic [31:0] STEP_SL_FAST   = step_of(SERLATCH_FAST_HZ);
    localparam logic [31:0] STEP_SNES      = step_of(SNES_COMPAT_HZ);
    localparam logic [31:0] STEP_PCE       = step_of(PCE_NORMAL_HZ);

    snac_type_e  type_r;
    logic [31:0] step;
    logic [31:0] acc;

    // Type sampled once, decode registered in the same cycle
    always_ff @(posedge i_clk) begin
        type_r    <= i_cont_type;
        o_restart <= i_rst || (type_r != i_cont_type);
        if (i_rst) begin
            o_sel    <= '0;
            o_sl_var <= SL_DB15;
            step     <= '0;
        end else begin
            o_sel    <= '0;
            o_sl_var <= SL_DB15;
            step     <= '0;
            case (i_cont_type)
                DB15: begin
                    o_sel.serlatch_en <= 1'b1;
                    step              <= STEP_SL_NORMAL;
                end
                DB15_FAST: begin
                    o_sel.serlatch_en <= 1'b1;
                    step              <= STEP_SL_FAST;
                end
                NES: begin
                    o_sel.serlatch_en <= 1'b1;
                    o_sl_var          <= SL_NES;
                    step              <= STEP_SNES;
                end
                SNES: begin
                    o_sel.serlatch_en <= 1'b1;
                    o_sl_var          <= SL_SNES;
                    step              <= STEP_SNES;
                end
                SNES_SWAP: begin
                    o_sel.serlatch_en <= 1'b1;
                    o_sl_var          <= SL_SNES_SWAP;
                    step              <= STEP_SNES;
                end
                PCE_2BTN: begin
                    o_sel.pce_en <= 1'b1;
                    step         <= STEP_PCE;
                end
                // Disabled and unknown codes
                default: ;
            endcase
        end
    end

    // Strobe is the carry out of the phase accumulator
    always_ff @(posedge i_clk) begin
        if (i_rst || o_restart) begin
            acc   <= '0;
            o_stb <= 1'b0;
        end else begin
            {o_stb, acc} <= {1'b0, acc} + {1'b0, step};
        end
    end

    // Step under half the clock keeps the strobe a one-cycle pulse
    a_stb_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stb |=> !o_stb);

endmodule

`default_nettype wire

// File: snac_pce_reader.sv
// Clear and select FSM reading one PC Engine 2-button pad, one phase per strobe
`timescale 1ns/100ps
`default_nettype none

module snac_pce_reader import snac_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_restart,
    input  wire logic     i_en,
    input  wire logic     i_stb,
    input  wire cart_in_t i_pins,
    output snac_drive_t   o_drive,
    output btn_word_t     o_p1
);

    typedef enum logic [1:0] {
        IDLE,
        CLR,
        SEL_HI,
        SEL_LO
    } pce_state_e;

    pce_state_e state;
    logic [3:0] dir_q;
    logic [3:0] nib;

    // Pad nibble through the harness, active low
    assign nib = ~{i_pins.in7, i_pins.io3, i_pins.io6, i_pins.in4};

    always_ff @(posedge i_clk) begin
        if (i_restart || !i_en) begin
            state <= IDLE;
            o_p1  <= '0;
        end else if (i_stb) begin
            case (state)
                IDLE:  state <= CLR;
                CLR:   state <= SEL_HI;
                SEL_HI: begin
                    // Select high shows the directions
                    dir_q <= nib;
                    state <= SEL_LO;
                end
                SEL_LO: begin
                    // Select low shows the buttons, word complete
                    o_p1  <= {8'h00, nib, dir_q};
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Clear pulse on out1
    assign o_drive.out1 = (state == CLR);
    // Select held high through clear and the direction read
    assign o_drive.out2 = (state == CLR) || (state == SEL_HI);
    // io5 unused by this pad
    assign o_drive.io5  = 1'b0;

    // Losing the enable inside a frame always comes with a restart
    a_en_hold: assert property (@(posedge i_clk) disable iff (i_restart)
        (state != IDLE) |-> i_en);

endmodule

`default_nettype wire

// File: snac_pkg.sv
// Shared types and polling constants for the SNAC controller readers, imported by every RTL module
`default_nettype none

package snac_pkg;

    // Controller type codes as seen on the core's setting bus
    // Codes not listed here behave as disabled
    typedef enum logic [4:0] {
        DISABLED  = 5'd0,
        DB15      = 5'd1,
        NES       = 5'd2,
        SNES      = 5'd3,
        PCE_2BTN  = 5'd4,
        DB15_FAST = 5'd9,
        SNES_SWAP = 5'd11
    } snac_type_e;

    // Polling rates in Hz
    // The strobe accumulator runs at twice these
    localparam logic [31:0] SERLATCH_NORMAL_HZ = 32'd200_000;
    localparam logic [31:0] SERLATCH_FAST_HZ   = 32'd400_000;
    localparam logic [31:0] SNES_COMPAT_HZ     = 32'd50_000;
    localparam logic [31:0] PCE_NORMAL_HZ      = 32'd40_000;

    // One bit per button, 1 is pressed
    typedef logic [15:0] btn_word_t;

    // Reader enables, one hot or all zero
    typedef struct packed {
        logic serlatch_en;
        logic pce_en;
    } reader_sel_t;

    // Serial-latch flavours sharing one FSM
    typedef enum logic [1:0] {
        SL_DB15,
        SL_NES,
        SL_SNES,
        SL_SNES_SWAP
    } serlatch_var_e;

    // Adapter inputs after the synchronizer
    typedef struct packed {
        logic io3;
        logic in4;
        logic io6;
        logic in7;
    } cart_in_t;

    // Adapter outputs driven by a reader
    typedef struct packed {
        logic out1;
        logic out2;
        logic io5;
    } snac_drive_t;

    // Bits clocked per serial frame, NES only fills the low byte
    localparam int SNES_BITS      = 16;
    localparam int NES_VALID_BITS = 8;

endpackage

`default_nettype wire

// File: snac_port_combiner.sv
// Cartridge pin synchronizer and router, merges reader drives and button words for the core
`timescale 1ns/100ps
`default_nettype none

module snac_port_combiner import snac_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire reader_sel_t i_sel,
    input  wire logic [7:4]  i_cart_bk0,
    input  wire logic        i_cart_pin31,
    input  wire snac_drive_t i_sl_drive,
    input  wire snac_drive_t i_pce_drive,
    input  wire btn_word_t   i_sl_p1,
    input  wire btn_word_t   i_sl_p2,
    input  wire btn_word_t   i_pce_p1,
    output cart_in_t         o_pins,
    output logic             o_cart_bk0_dir,
    output logic [1:0]       o_cart_bk1,
    output logic             o_cart_pin30,
    output logic             o_cart_pin30_dir,
    output logic             o_cart_pin31_dir,
    output btn_word_t        o_p1_btn,
    output btn_word_t        o_p2_btn
);

    cart_in_t    pins_meta;
    snac_drive_t drive_q;

    // Two-stage synchronizer, configuration A pin map
    always_ff @(posedge i_clk) begin
        pins_meta.in4 <= i_cart_bk0[7];
        pins_meta.in7 <= i_cart_bk0[5];
        pins_meta.io3 <= i_cart_bk0[4];
        pins_meta.io6 <= i_cart_pin31;
        o_pins        <= pins_meta;
    end

    // Only the enabled reader reaches the pins
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            drive_q <= '0;
        end else if (i_sel.serlatch_en) begin
            drive_q <= i_sl_drive;
        end else if (i_sel.pce_en) begin
            drive_q <= i_pce_drive;
        end else begin
            drive_q <= '0;
        end
    end

    // bank1 bit 7 is out2, bit 6 is out1
    assign o_cart_bk1   = {drive_q.out2, drive_q.out1};
    assign o_cart_pin30 = drive_q.io5;

    // Fixed directions, bank0 and pin31 in, pin30 out
    assign o_cart_bk0_dir   = 1'b0;
    assign o_cart_pin30_dir = 1'b1;
    assign o_cart_pin31_dir = 1'b0;

    // Player words from the active reader
    always_comb begin
        if (i_sel.serlatch_en) begin
            o_p1_btn = i_sl_p1;
            o_p2_btn = i_sl_p2;
        end else if (i_sel.pce_en) begin
            o_p1_btn = i_pce_p1;
            o_p2_btn = '0;
        end else begin
            o_p1_btn = '0;
            o_p2_btn = '0;
        end
    end

endmodule

`default_nettype wire

// File: snac_serlatch_reader.sv
// Latch and clock FSM reading two DB15, NES or SNES pads, one bit phase per strobe
`timescale 1ns/100ps
`default_nettype none

module snac_serlatch_reader import snac_pkg::*; (
    input  wire logic          i_clk,
    input  wire logic          i_restart,
    input  wire logic          i_en,
    input  wire serlatch_var_e i_var,
    input  wire logic          i_stb,
    input  wire cart_in_t      i_pins,
    output snac_drive_t        o_drive,
    output btn_word_t          o_p1,
    output btn_word_t          o_p2
);

    typedef enum logic [1:0] {
        IDLE,
        LATCH,
        CLK_LO,
        CLK_HI
    } sl_state_e;

    sl_state_e  state;
    logic [3:0] bit_cnt;
    btn_word_t  sh1;
    btn_word_t  sh2;
    logic       d1;

    // Post-processing applied once the frame is complete
    function automatic btn_word_t finish(input btn_word_t raw, input serlatch_var_e v);
        btn_word_t w;
        w = raw;
        case (v)
            SL_NES: w[15:NES_VALID_BITS] = '0;
            SL_SNES_SWAP: begin
                // A/B swapped with X/Y
                w[0] = raw[1];
                w[1] = raw[0];
                w[8] = raw[9];
                w[9] = raw[8];
            end
            default: ;
        endcase
        return w;
    endfunction

    // DB15 has its data on both io3 and io6, pressed pulls low
    assign d1 = (i_var == SL_DB15) ? (i_pins.io3 & i_pins.io6) : i_pins.io3;

    always_ff @(posedge i_clk) begin
        if (i_restart || !i_en) begin
            state   <= IDLE;
            bit_cnt <= '0;
            o_p1    <= '0;
            o_p2    <= '0;
        end else if (i_stb) begin
            case (state)
                IDLE: begin
                    state   <= LATCH;
                    bit_cnt <= '0;
                end
                LATCH: state <= CLK_LO;
                CLK_LO: begin
                    // Sample as the clock goes high, data is still bit k
                    sh1[bit_cnt] <= ~d1;
                    sh2[bit_cnt] <= ~i_pins.in7;
                    state        <= CLK_HI;
                end
                CLK_HI: begin
                    if (bit_cnt == 4'(SNES_BITS - 1)) begin
                        o_p1  <= finish(sh1, i_var);
                        o_p2  <= finish(sh2, i_var);
                        state <= IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                        state   <= CLK_LO;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Latch on out2, shared clock on out1, second pad clock on io5
    assign o_drive.out2 = (state == LATCH);
    assign o_drive.out1 = (state == CLK_HI);
    assign o_drive.io5  = (state == CLK_HI);

    // A variant change inside a frame always comes with a restart
    a_var_hold: assert property (@(posedge i_clk) disable iff (i_restart || !i_en)
        (state != IDLE) |-> $stable(i_var));

endmodule

`default_nettype wire

// File: snac_top.sv
// SNAC adapter top level, polls the selected controller type and returns two player words
`timescale 1ns/100ps
`default_nettype none

module snac_top import snac_pkg::*; #(
    parameter int unsigned MASTER_CLK_FREQ = 50_000_000
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire snac_type_e i_cont_type,
    input  wire logic [7:4] i_cart_bk0,
    input  wire logic       i_cart_pin31,
    output logic            o_cart_bk0_dir,
    output logic [1:0]      o_cart_bk1,
    output logic            o_cart_pin30,
    output logic            o_cart_pin30_dir,
    output logic            o_cart_pin31_dir,
    output btn_word_t       o_p1_btn,
    output btn_word_t       o_p2_btn
);

    reader_sel_t   sel;
    serlatch_var_e sl_var;
    logic          stb;
    logic          restart;
    cart_in_t      pins;
    snac_drive_t   sl_drive;
    snac_drive_t   pce_drive;
    btn_word_t     sl_p1;
    btn_word_t     sl_p2;
    btn_word_t     pce_p1;

    // Type decode and strobe pacing
    snac_mode_ctrl #(
        .MASTER_CLK_FREQ(MASTER_CLK_FREQ)
    ) u_mode (
        .i_clk(i_clk), .i_rst(i_rst), .i_cont_type(i_cont_type),
        .o_sel(sel), .o_sl_var(sl_var), .o_stb(stb), .o_restart(restart)
    );

    // DB15, NES and SNES pads
    snac_serlatch_reader u_sl (
        .i_clk(i_clk), .i_restart(restart), .i_en(sel.serlatch_en), .i_var(sl_var),
        .i_stb(stb), .i_pins(pins), .o_drive(sl_drive), .o_p1(sl_p1), .o_p2(sl_p2)
    );

    // PC Engine 2-button pad
    snac_pce_reader u_pce (
        .i_clk(i_clk), .i_restart(restart), .i_en(sel.pce_en), .i_stb(stb),
        .i_pins(pins), .o_drive(pce_drive), .o_p1(pce_p1)
    );

    snac_port_combiner u_port (
        .i_clk(i_clk), .i_rst(i_rst), .i_sel(sel),
        .i_cart_bk0(i_cart_bk0), .i_cart_pin31(i_cart_pin31),
        .i_sl_drive(sl_drive), .i_pce_drive(pce_drive),
        .i_sl_p1(sl_p1), .i_sl_p2(sl_p2), .i_pce_p1(pce_p1),
        .o_pins(pins), .o_cart_bk0_dir(o_cart_bk0_dir), .o_cart_bk1(o_cart_bk1),
        .o_cart_pin30(o_cart_pin30), .o_cart_pin30_dir(o_cart_pin30_dir),
        .o_cart_pin31_dir(o_cart_pin31_dir), .o_p1_btn(o_p1_btn), .o_p2_btn(o_p2_btn)
    );

endmodule

`default_nettype wire

// File: tb_pad_model.sv
// Behavioral pads for the testbench, answer on the cartridge pins from the words loaded into them
`timescale 1ns/100ps
`default_nettype none

module tb_pad_model import snac_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_pce_mode,
    input  wire logic       i_io6_pad2,
    input  wire btn_word_t  i_word1,
    input  wire btn_word_t  i_word2,
    input  wire logic [1:0] i_bk1,
    input  wire logic       i_pin30,
    output logic [7:4]      o_bk0,
    output logic            o_pin31
);

    btn_word_t  sh1;
    btn_word_t  sh2;
    logic       clk1_q;
    logic       clk2_q;
    logic       sel_q;
    logic [3:0] nib;

    initial begin
        sh1    = '0;
        sh2    = '0;
        clk1_q = 1'b0;
        clk2_q = 1'b0;
        sel_q  = 1'b0;
    end

    // Pins watched on the falling edge, away from the DUT's register updates
    always @(negedge i_clk) begin
        clk1_q <= i_bk1[0];
        clk2_q <= i_pin30;
        sel_q  <= i_bk1[1];
        if (i_bk1[1]) begin
            // Latch high keeps reloading, bit 0 shows first
            sh1 <= i_word1;
            sh2 <= i_word2;
        end else begin
            // Each rising clock moves to the next bit, empty bits read released
            if (i_bk1[0] && !clk1_q)
                sh1 <= {1'b0, sh1[15:1]};
            if (i_pin30 && !clk2_q)
                sh2 <= {1'b0, sh2[15:1]};
        end
    end

    // PCE pad shows directions while select is high, buttons while low
    assign nib = sel_q ? i_word1[3:0] : i_word1[7:4];

    // All lines active low
    always_comb begin
        o_bk0[6] = 1'b1;
        if (i_pce_mode) begin
            o_bk0[5] = ~nib[3];
            o_bk0[4] = ~nib[2];
            o_pin31  = ~nib[1];
            o_bk0[7] = ~nib[0];
        end else begin
            o_bk0[7] = 1'b1;
            o_bk0[5] = ~sh2[0];
            o_bk0[4] = ~sh1[0];
            // Second DB15 data line carries the other pad when enabled
            o_pin31  = i_io6_pad2 ? ~sh2[0] : 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: tb_snac.sv
// Testbench for snac_top, runs each controller type against the pad models and checks the words
`timescale 1ns/100ps
`default_nettype none

module tb_snac import snac_pkg::*; ();

    localparam int unsigned CLK_FREQ = 10_000_000;
    localparam int NROWS = 7;
    localparam int FRAME_TIMEOUT = 40_000;
    localparam int IDLE_WATCH = 2_000;

    // Stimulus and expected words of one row, names kept alongside
    typedef struct packed {
        snac_type_e ctype;
        logic       io6_pad2;
        btn_word_t  pad1;
        btn_word_t  pad2;
        btn_word_t  exp1;
        btn_word_t  exp2;
    } row_t;

    logic        clk;
    logic        rst;
    snac_type_e  cont_type;
    logic [7:4]  cart_bk0;
    logic        cart_pin31;
    logic        bk0_dir;
    logic [1:0]  cart_bk1;
    logic        cart_pin30;
    logic        pin30_dir;
    logic        pin31_dir;
    btn_word_t   p1_btn;
    btn_word_t   p2_btn;
    logic        pce_mode;
    logic        io6_pad2;
    btn_word_t   pad1_word;
    btn_word_t   pad2_word;
    logic [15:0] lfsr;
    int          err_count;
    row_t        rows[NROWS];
    string       names[NROWS];

    snac_top #(
        .MASTER_CLK_FREQ(CLK_FREQ)
    ) uut (
        .i_clk(clk), .i_rst(rst), .i_cont_type(cont_type),
        .i_cart_bk0(cart_bk0), .i_cart_pin31(cart_pin31),
        .o_cart_bk0_dir(bk0_dir), .o_cart_bk1(cart_bk1), .o_cart_pin30(cart_pin30),
        .o_cart_pin30_dir(pin30_dir), .o_cart_pin31_dir(pin31_dir),
        .o_p1_btn(p1_btn), .o_p2_btn(p2_btn)
    );

    tb_pad_model pads (
        .i_clk(clk), .i_pce_mode(pce_mode), .i_io6_pad2(io6_pad2),
        .i_word1(pad1_word), .i_word2(pad2_word), .i_bk1(cart_bk1), .i_pin30(cart_pin30),
        .o_bk0(cart_bk0), .o_pin31(cart_pin31)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // NES and PCE only fill the low byte
    function automatic btn_word_t low_byte(input btn_word_t w);
        return {8'h00, w[7:0]};
    endfunction

    // A/B trade places with X/Y
    function automatic btn_word_t swap_expect(input btn_word_t w);
        btn_word_t r;
        r = w;
        r[0] = w[1];
        r[1] = w[0];
        r[8] = w[9];
        r[9] = w[8];
        return r;
    endfunction

    // One LFSR step per bit of the pad word
    task automatic draw_word(output btn_word_t w);
        for (int b = 0; b < 16; b++) begin
            lfsr = next_lfsr(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    task automatic stop_run(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp)
        else stop_run($sformatf("Error %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic add_row(input int idx, input string name, input snac_type_e t,
                           input logic io6, input btn_word_t w1, input btn_word_t w2,
                           input btn_word_t e1, input btn_word_t e2);
        names[idx] = name;
        rows[idx]  = '{ctype: t, io6_pad2: io6, pad1: w1, pad2: w2, exp1: e1, exp2: e2};
    endtask

    // Counts rising latch or select edges at the pins
    task automatic wait_frames(input string name, input int n);
        int   seen;
        int   cycles;
        logic prev;
        seen   = 0;
        cycles = 0;
        prev   = cart_bk1[1];
        while (seen < n) begin
            @(negedge clk);
            if (cart_bk1[1] && !prev)
                seen++;
            prev = cart_bk1[1];
            cycles++;
            if (cycles > FRAME_TIMEOUT)
                stop_run($sformatf("Timeout: %s saw only %0d of %0d frame starts",
                                   name, seen, n));
        end
    endtask

    task automatic wait_zero_words(input string name);
        int cycles;
        cycles = 0;
        while (p1_btn != 16'h0000 || p2_btn != 16'h0000) begin
            @(negedge clk);
            cycles++;
            if (cycles > FRAME_TIMEOUT)
                stop_run($sformatf("Timeout: %s button words never went to zero", name));
        end
    endtask

    task automatic watch_idle_pins(input string name);
        repeat (IDLE_WATCH) begin
            @(negedge clk);
            check_value({name, " bank1"}, 16'h0000, {14'd0, cart_bk1});
            check_value({name, " pin30"}, 16'h0000, {15'd0, cart_pin30});
        end
    endtask

    task automatic run_row(input int i);
        @(negedge clk);
        pad1_word = rows[i].pad1;
        pad2_word = rows[i].pad2;
        io6_pad2  = rows[i].io6_pad2;
        pce_mode  = (rows[i].ctype == PCE_2BTN);
        cont_type = rows[i].ctype;
        if (rows[i].ctype == DISABLED) begin
            wait_zero_words(names[i]);
            watch_idle_pins(names[i]);
        end else begin
            // A stray latch from the old type may count, four leave two full frames
            wait_frames(names[i], 4);
        end
        check_value({names[i], " p1"}, rows[i].exp1, p1_btn);
        check_value({names[i], " p2"}, rows[i].exp2, p2_btn);
    endtask

    initial begin
        btn_word_t w1;
        btn_word_t w2;
        err_count = 0;
        lfsr      = 16'd49;
        rst       = 1'b1;
        cont_type = DISABLED;
        pce_mode  = 1'b0;
        io6_pad2  = 1'b0;
        pad1_word = '0;
        pad2_word = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Idle pins and fixed directions out of reset
        check_value("reset p1", 16'h0000, p1_btn);
        check_value("reset p2", 16'h0000, p2_btn);
        check_value("reset bank1", 16'h0000, {14'd0, cart_bk1});
        check_value("reset pin30", 16'h0000, {15'd0, cart_pin30});
        check_value("reset bank0 dir", 16'h0000, {15'd0, bk0_dir});
        check_value("reset pin30 dir", 16'h0001, {15'd0, pin30_dir});
        check_value("reset pin31 dir", 16'h0000, {15'd0, pin31_dir});

        draw_word(w1);
        draw_word(w2);
        add_row(0, "snes", SNES, 1'b0, w1, w2, w1, w2);
        draw_word(w1);
        draw_word(w2);
        add_row(1, "db15_fast", DB15_FAST, 1'b0, w1, w2, w1, w2);
        draw_word(w1);
        draw_word(w2);
        add_row(2, "nes", NES, 1'b0, w1, w2, low_byte(w1), low_byte(w2));
        draw_word(w1);
        draw_word(w2);
        add_row(3, "snes_swap", SNES_SWAP, 1'b0, w1, w2, swap_expect(w1), swap_expect(w2));
        // Player 1 pressed on either data line
        draw_word(w1);
        draw_word(w2);
        add_row(4, "db15", DB15, 1'b1, w1, w2, w1 | w2, w2);
        draw_word(w1);
        draw_word(w2);
        add_row(5, "pce", PCE_2BTN, 1'b0, w1, w2, low_byte(w1), 16'h0000);
        draw_word(w1);
        draw_word(w2);
        add_row(6, "disabled", DISABLED, 1'b0, w1, w2, 16'h0000, 16'h0000);

        for (int i = 0; i < NROWS; i++)
            run_row(i);

        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
